// File: hw/rv_fetch_config.svh
`ifndef RV_FETCH_CONFIG_SVH
`define RV_FETCH_CONFIG_SVH

// address and instruction width
`define RV_FETCH_ADDR_W 32

// first pc fetched after reset
`define RV_FETCH_RESET_PC 32'h8000_0000

// number of cache lines, power of two
// log2 of this is the index width
`define RV_FETCH_LINES 16

// words per cache line, power of two
// burst length on memory side is this minus one
`define RV_FETCH_LINE_WORDS 4

// tag width = addr width - index bits - word offset bits - 2 byte bits

`endif

// File: hw/rv_fetch_pkg.sv
package rv_fetch_pkg;

	// icache controller states
	typedef enum logic [2:0] {
		// waiting for a fetch request
		IC_IDLE    = 3'd0,
		// tag compare on the latched address
		IC_LOOKUP  = 3'd1,
		// burst beats coming in from memory
		IC_REFILL  = 3'd2,
		// requested word handed back after refill
		IC_RESPOND = 3'd3,
		// one valid bit cleared per cycle
		IC_FLUSH   = 3'd4
	} icache_state_e;

	// rv32 major opcodes, bits [6:0]
	// only misc_mem matters to fetch, the rest are for waveforms
	typedef enum logic [6:0] {
		OP_LOAD     = 7'b000_0011,
		OP_MISC_MEM = 7'b000_1111,
		OP_OP_IMM   = 7'b001_0011,
		OP_AUIPC    = 7'b001_0111,
		OP_STORE    = 7'b010_0011,
		OP_OP       = 7'b011_0011,
		OP_LUI      = 7'b011_0111,
		OP_BRANCH   = 7'b110_0011,
		OP_JALR     = 7'b110_0111,
		OP_JAL      = 7'b110_1111,
		OP_SYSTEM   = 7'b111_0011
	} rv_opcode_e;

endpackage

// File: hw/icache.sv
`timescale 1ns/10ps
`include "rv_fetch_config.svh"

module icache (
	input  logic                        clock,
	input  logic                        reset,
	// fetch request side
	input  logic                        fetch_valid_i,
	input  logic [`RV_FETCH_ADDR_W-1:0] fetch_addr_i,
	output logic                        fetch_ready_o,
	output logic [`RV_FETCH_ADDR_W-1:0] fetch_data_o,
	// invalidate all lines
	input  logic                        flush_i,
	// burst read port to memory
	output logic                        mem_req_valid_o,
	output logic [`RV_FETCH_ADDR_W-1:0] mem_req_addr_o,
	output logic [7:0]                  mem_req_len_o,
	input  logic                        mem_req_ready_i,
	input  logic [`RV_FETCH_ADDR_W-1:0] mem_data_i,
	input  logic                        mem_last_i
);

	import rv_fetch_pkg::*;

	localparam int AW    = `RV_FETCH_ADDR_W;
	localparam int LINES = `RV_FETCH_LINES;
	localparam int WORDS = `RV_FETCH_LINE_WORDS;
	localparam int IDX_W = $clog2(LINES);
	localparam int OFF_W = $clog2(WORDS);
	// two byte offset bits below the word offset
	localparam int TAG_W = AW - IDX_W - OFF_W - 2;

	// storage
	logic [TAG_W-1:0] tag_mem  [LINES];
	logic [AW-1:0]    data_mem [LINES*WORDS];
	logic [LINES-1:0] valid_q;

	icache_state_e    state_q;
	// address of the request being served
	logic [AW-1:0]    req_addr_q;
	logic [OFF_W-1:0] beat_cnt_q;
	logic [IDX_W-1:0] flush_cnt_q;
	// flush seen while busy, run once back in idle
	logic             flush_pend_q;

	logic [TAG_W-1:0] req_tag;
	logic [IDX_W-1:0] req_idx;
	logic [OFF_W-1:0] req_off;
	logic             hit;

	// address split
	assign req_tag = req_addr_q[AW-1 -: TAG_W];
	assign req_idx = req_addr_q[2+OFF_W +: IDX_W];
	assign req_off = req_addr_q[2 +: OFF_W];

	assign hit = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

	// answer straight from lookup on a hit, else after the refill
	assign fetch_ready_o = ((state_q == IC_LOOKUP) && hit) || (state_q == IC_RESPOND);
	assign fetch_data_o  = data_mem[{req_idx, req_off}];

	// line aligned burst, length field is beats minus one
	assign mem_req_addr_o = {req_addr_q[AW-1:OFF_W+2], {(OFF_W+2){1'b0}}};
	assign mem_req_len_o  = 8'(WORDS - 1);

	// controller
	always_ff @(posedge clock) begin
		if (reset) begin
			// reset clears the valid bits through the normal flush walk
			state_q         <= IC_FLUSH;
			flush_cnt_q     <= '0;
			flush_pend_q    <= 1'b0;
			beat_cnt_q      <= '0;
			mem_req_valid_o <= 1'b0;
		end else begin
			if (flush_i && (state_q != IC_IDLE)) begin
				flush_pend_q <= 1'b1;
			end
			case (state_q)
				IC_IDLE: begin
					// flush wins over a waiting request
					if (flush_i || flush_pend_q) begin
						state_q      <= IC_FLUSH;
						flush_cnt_q  <= '0;
						flush_pend_q <= 1'b0;
					end else if (fetch_valid_i) begin
						state_q <= IC_LOOKUP;
					end
				end
				IC_LOOKUP: begin
					if (hit) begin
						state_q <= IC_IDLE;
					end else begin
						// miss, single address phase then beats
						state_q         <= IC_REFILL;
						beat_cnt_q      <= '0;
						mem_req_valid_o <= 1'b1;
					end
				end
				IC_REFILL: begin
					// ready marks a data beat, the first one closes the address phase
					if (mem_req_ready_i) begin
						mem_req_valid_o <= 1'b0;
						beat_cnt_q      <= beat_cnt_q + OFF_W'(1);
						if (mem_last_i) begin
							state_q <= IC_RESPOND;
						end
					end
				end
				IC_RESPOND: begin
					state_q <= IC_IDLE;
				end
				IC_FLUSH: begin
					flush_cnt_q <= flush_cnt_q + IDX_W'(1);
					if (flush_cnt_q == IDX_W'(LINES - 1)) begin
						state_q <= IC_IDLE;
					end
				end
				default: begin
					state_q <= IC_IDLE;
				end
			endcase
		end
	end

	// request address latched when taken
	always_ff @(posedge clock) begin
		if ((state_q == IC_IDLE) && !flush_i && !flush_pend_q && fetch_valid_i) begin
			req_addr_q <= fetch_addr_i;
		end
	end

	// arrays
	// beats fill the line in order, tag and valid written with the last one
	always_ff @(posedge clock) begin
		if ((state_q == IC_REFILL) && mem_req_ready_i) begin
			data_mem[{req_idx, beat_cnt_q}] <= mem_data_i;
			if (mem_last_i) begin
				tag_mem[req_idx] <= req_tag;
				valid_q[req_idx] <= 1'b1;
			end
		end
		if (state_q == IC_FLUSH) begin
			valid_q[flush_cnt_q] <= 1'b0;
		end
	end

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/10ps
`include "rv_fetch_config.svh"

module fetch_unit (
	input  logic                        clock,
	input  logic                        reset,
	// redirect from execute
	input  logic                        redirect_valid_i,
	input  logic [`RV_FETCH_ADDR_W-1:0] redirect_pc_i,
	// icache request side
	output logic                        fetch_valid_o,
	output logic [`RV_FETCH_ADDR_W-1:0] fetch_addr_o,
	input  logic                        fetch_ready_i,
	input  logic [`RV_FETCH_ADDR_W-1:0] fetch_data_i,
	output logic                        flush_o,
	// decode side
	output logic                        id_valid_o,
	output logic [`RV_FETCH_ADDR_W-1:0] id_pc_o,
	output logic [`RV_FETCH_ADDR_W-1:0] id_inst_o,
	input  logic                        id_ready_i
);

	import rv_fetch_pkg::*;

	localparam int AW = `RV_FETCH_ADDR_W;
	localparam logic [AW-1:0] PC_STEP = AW'(4);

	// next pc to fetch, jumps straight to a redirect target
	logic [AW-1:0] pc_q;
	// outstanding word belongs to a stream that was redirected away
	logic          drop_q;
	logic          id_accept;
	logic          word_ok;
	logic          issue;
	logic          is_fence_i;

	assign id_accept = id_valid_o && id_ready_i;

	// returned word is kept unless stale or killed this cycle
	assign word_ok = fetch_ready_i && !drop_q && !redirect_valid_i;

	// one request at a time
	// output slot must be free by the time the word comes back
	assign issue = !fetch_valid_o && !redirect_valid_i && (!id_valid_o || id_ready_i);

	// fence.i is misc_mem with funct3 bit 0 set
	assign is_fence_i = (rv_opcode_e'(id_inst_o[6:0]) == OP_MISC_MEM) && id_inst_o[12];

	// cache invalidate as decode takes the fence.i
	// the request issued in this same cycle waits for the flush to finish
	assign flush_o = id_accept && is_fence_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= `RV_FETCH_RESET_PC;
		end else if (redirect_valid_i) begin
			pc_q <= redirect_pc_i;
		end else if (word_ok) begin
			pc_q <= pc_q + PC_STEP;
		end
	end

	// request valid, high straight out of reset for the reset pc
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_valid_o <= 1'b1;
		end else if (issue) begin
			fetch_valid_o <= 1'b1;
		end else if (fetch_ready_i) begin
			fetch_valid_o <= 1'b0;
		end
	end

	// request address frozen while outstanding
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_addr_o <= `RV_FETCH_RESET_PC;
		end else if (issue) begin
			fetch_addr_o <= pc_q;
		end
	end

	// redirect with a word still in the cache
	// that word is thrown away when it arrives
	always_ff @(posedge clock) begin
		if (reset) begin
			drop_q <= 1'b0;
		end else if (redirect_valid_i && fetch_valid_o && !fetch_ready_i) begin
			drop_q <= 1'b1;
		end else if (fetch_ready_i) begin
			drop_q <= 1'b0;
		end
	end

	// decode output valid
	always_ff @(posedge clock) begin
		if (reset) begin
			id_valid_o <= 1'b0;
		end else if (redirect_valid_i) begin
			id_valid_o <= 1'b0;
		end else if (word_ok) begin
			id_valid_o <= 1'b1;
		end else if (id_ready_i) begin
			id_valid_o <= 1'b0;
		end
	end

	// pc and instruction held until decode accepts
	always_ff @(posedge clock) begin
		if (word_ok) begin
			id_pc_o   <= fetch_addr_o;
			id_inst_o <= fetch_data_i;
		end
	end

endmodule

// File: hw/rv_fetch_top.sv
`timescale 1ns/10ps
`include "rv_fetch_config.svh"

module rv_fetch_top (
	input  logic                        clock,
	input  logic                        reset,
	// redirect from execute
	input  logic                        redirect_valid_i,
	input  logic [`RV_FETCH_ADDR_W-1:0] redirect_pc_i,
	// memory burst read port
	output logic                        mem_req_valid_o,
	output logic [`RV_FETCH_ADDR_W-1:0] mem_req_addr_o,
	output logic [7:0]                  mem_req_len_o,
	input  logic                        mem_req_ready_i,
	input  logic [`RV_FETCH_ADDR_W-1:0] mem_data_i,
	input  logic                        mem_last_i,
	// decode port
	output logic                        id_valid_o,
	output logic [`RV_FETCH_ADDR_W-1:0] id_pc_o,
	output logic [`RV_FETCH_ADDR_W-1:0] id_inst_o,
	input  logic                        id_ready_i
);

	// fetch unit to cache
	logic                        fetch_valid;
	logic [`RV_FETCH_ADDR_W-1:0] fetch_addr;
	logic                        fetch_ready;
	logic [`RV_FETCH_ADDR_W-1:0] fetch_data;
	logic                        flush;

	fetch_unit u_fetch_unit (
		.clock            (clock),
		.reset            (reset),
		.redirect_valid_i (redirect_valid_i),
		.redirect_pc_i    (redirect_pc_i),
		.fetch_valid_o    (fetch_valid),
		.fetch_addr_o     (fetch_addr),
		.fetch_ready_i    (fetch_ready),
		.fetch_data_i     (fetch_data),
		.flush_o          (flush),
		.id_valid_o       (id_valid_o),
		.id_pc_o          (id_pc_o),
		.id_inst_o        (id_inst_o),
		.id_ready_i       (id_ready_i)
	);

	icache u_icache (
		.clock           (clock),
		.reset           (reset),
		.fetch_valid_i   (fetch_valid),
		.fetch_addr_i    (fetch_addr),
		.fetch_ready_o   (fetch_ready),
		.fetch_data_o    (fetch_data),
		.flush_i         (flush),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_req_addr_o  (mem_req_addr_o),
		.mem_req_len_o   (mem_req_len_o),
		.mem_req_ready_i (mem_req_ready_i),
		.mem_data_i      (mem_data_i),
		.mem_last_i      (mem_last_i)
	);

endmodule

// File: sim/rv_fetch_sva.sv
`timescale 1ns/10ps
`include "rv_fetch_config.svh"

module rv_fetch_sva (
	input logic                        clock,
	input logic                        reset,
	input logic                        redirect_valid_i,
	input logic                        mem_req_valid_o,
	input logic [`RV_FETCH_ADDR_W-1:0] mem_req_addr_o,
	input logic [7:0]                  mem_req_len_o,
	input logic                        mem_req_ready_i,
	input logic                        id_valid_o,
	input logic [`RV_FETCH_ADDR_W-1:0] id_pc_o,
	input logic [`RV_FETCH_ADDR_W-1:0] id_inst_o,
	input logic                        id_ready_i
);

	// byte offset bits of one line
	localparam int OFF_W = $clog2(`RV_FETCH_LINE_WORDS) + 2;

	// line aligned request, length is beats minus one
	burst_form: assert property (@(posedge clock) disable iff (reset)
		mem_req_valid_o |-> (mem_req_addr_o[OFF_W-1:0] == '0)
			&& (mem_req_len_o == 8'(`RV_FETCH_LINE_WORDS - 1)))
		else $error("burst request not line aligned or wrong length");

	// address phase held until the first beat
	burst_hold: assert property (@(posedge clock) disable iff (reset)
		mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o
			&& $stable(mem_req_addr_o) && $stable(mem_req_len_o))
		else $error("burst request changed while waiting for ready");

	// decode stall keeps the output register
	id_hold: assert property (@(posedge clock) disable iff (reset)
		id_valid_o && !id_ready_i && !redirect_valid_i |=> id_valid_o
			&& $stable(id_pc_o) && $stable(id_inst_o))
		else $error("decode output changed during a stall");

	// redirect empties the output slot
	redirect_kill: assert property (@(posedge clock) disable iff (reset)
		redirect_valid_i |=> !id_valid_o)
		else $error("decode output still valid after a redirect");

	// quiet outputs right after reset
	reset_quiet: assert property (@(posedge clock)
		$fell(reset) |-> !id_valid_o && !mem_req_valid_o)
		else $error("outputs active right after reset");

endmodule

bind rv_fetch_top rv_fetch_sva u_rv_fetch_sva (.*);

// File: sim/rv_fetch_tb.sv
`timescale 1ns/10ps
`include "rv_fetch_config.svh"

module rv_fetch_tb;

	import rv_fetch_pkg::*;

	localparam int AW = `RV_FETCH_ADDR_W;
	localparam logic [AW-1:0] FENCE_I = 32'h0000_100f;

	logic          clock;
	logic          reset;
	logic          redirect_valid_i;
	logic [AW-1:0] redirect_pc_i;
	logic          mem_req_valid_o;
	logic [AW-1:0] mem_req_addr_o;
	logic [7:0]    mem_req_len_o;
	logic          mem_req_ready_i;
	logic [AW-1:0] mem_data_i;
	logic          mem_last_i;
	logic          id_valid_o;
	logic [AW-1:0] id_pc_o;
	logic [AW-1:0] id_inst_o;
	logic          id_ready_i;

	logic [31:0]   lfsr_q = 32'hf88e;
	// pcs decode must see in order
	logic [AW-1:0] exp_q [$];
	// bursts seen per line address
	int            bursts [logic [AW-1:0]];

	rv_fetch_top UUT (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// taps 32 22 2 1
	// one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	// alu op everywhere except the fence.i table
	// low address bits folded into the top so each word of a line differs
	function automatic logic [AW-1:0] mem_word(input logic [AW-1:0] addr);
		logic [AW-1:0] word;
		word = addr ^ 32'h1357_9bdf ^ {addr[6:0], 25'd0};
		word[6:0] = OP_OP_IMM;
		case (addr)
			32'h8000_0408: word = FENCE_I;
			default: ;
		endcase
		return word;
	endfunction

	task automatic check_value(input string name, input logic [AW-1:0] got,
			input logic [AW-1:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("Verification failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout: %s", what);
		$display("Verification failed");
		$fatal(1, "timeout");
	endtask

	task automatic push_run(input logic [AW-1:0] start, input int count);
		for (int i = 0; i < count; i++) begin
			exp_q.push_back(start + AW'(4 * i));
		end
	endtask

	// burst memory with random gaps before every beat
	initial begin : mem_model
		int            idle;
		int            gaps;
		logic [AW-1:0] base;
		forever begin
			idle = 0;
			while (mem_req_valid_o !== 1'b1) begin
				@(posedge clock);
				#1;
				idle++;
				if (idle > 2000) timeout_fail("cache issued no burst for 2000 cycles");
			end
			base = mem_req_addr_o;
			bursts[base] = bursts[base] + 1;
			for (int k = 0; k <= int'(mem_req_len_o); k++) begin
				gaps = int'({lfsr_bit(), lfsr_bit()});
				repeat (gaps) begin
					@(posedge clock);
					#1;
				end
				mem_req_ready_i = 1'b1;
				mem_data_i      = mem_word(base + AW'(4 * k));
				mem_last_i      = (k == int'(mem_req_len_o));
				@(posedge clock);
				#1;
				mem_req_ready_i = 1'b0;
				mem_last_i      = 1'b0;
			end
		end
	end

	// decode and execute side
	initial begin : stimulus
		int n_xfer;
		int jumps;
		int quiet;
		redirect_valid_i = 1'b0;
		redirect_pc_i    = '0;
		mem_req_ready_i  = 1'b0;
		mem_data_i       = '0;
		mem_last_i       = 1'b0;
		id_ready_i       = 1'b0;
		reset            = 1'b1;
		n_xfer           = 0;
		jumps            = 0;
		quiet            = 0;
		// straight run then backward jump into cached lines then jump to a new line
		push_run(32'h8000_0000, 12);
		push_run(32'h8000_0010, 13);
		push_run(32'h8000_0400, 8);
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		while (exp_q.size() > 0) begin
			redirect_valid_i = 1'b0;
			if ((n_xfer == 12 && jumps == 0) || (n_xfer == 25 && jumps == 1)) begin
				redirect_valid_i = 1'b1;
				redirect_pc_i    = exp_q[0];
				id_ready_i       = 1'b0;
				jumps++;
			end else begin
				// decode stalls about a quarter of the cycles
				id_ready_i = lfsr_bit() | lfsr_bit();
				if (id_valid_o && id_ready_i) begin
					check_value("id_pc_o", id_pc_o, exp_q[0]);
					check_value("id_inst_o", id_inst_o, mem_word(exp_q[0]));
					void'(exp_q.pop_front());
					n_xfer++;
					quiet = 0;
				end
			end
			@(posedge clock);
			#1;
			quiet++;
			if (quiet > 400) timeout_fail("decode got no instruction for 400 cycles");
		end
		// lines 1 and 2 hit after the backward jump
		check_value("bursts line 8000_0010", bursts[32'h8000_0010], 1);
		check_value("bursts line 8000_0020", bursts[32'h8000_0020], 1);
		// fence.i forced a second refill of its own line
		check_value("bursts line 8000_0400", bursts[32'h8000_0400], 2);
		$display("Verification passed");
		$finish;
	end

endmodule

// File: rv_fetch.f
+incdir+hw
hw/rv_fetch_pkg.sv
hw/icache.sv
hw/fetch_unit.sv
hw/rv_fetch_top.sv
sim/rv_fetch_sva.sv
sim/rv_fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rv_fetch_tb -f rv_fetch.f -o rv_fetch_sim \
	&& ./obj_dir/rv_fetch_sim \
	|| { echo "simulation run returned a failure status"; exit 1; }
